/* rtl/tcb_full_lib_arbiter.sv */
//////////////////////////////////////////////////
// TCB round-robin arbiter
// picks one of the requesting managers by a priority
// order; the served manager drops to the end of the
// order at the edge that ends its transfer
//////////////////////////////////////////////////

module tcb_full_lib_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    // request valids, one per manager
    input  tcb_full_pkg::tcb_vld_t vld,
    // transfer completed this cycle
    input  logic                   xfr,
    // selected manager
    output tcb_full_pkg::tcb_sel_t sel,
    // some manager is requesting
    output logic                   gnt
);

//////////////////////////////////////////////////
// helper functions
//////////////////////////////////////////////////

    // gather valids in priority order
    // position 0 holds the highest priority manager
    function automatic tcb_full_pkg::tcb_vld_t reorder (
        tcb_full_pkg::tcb_vld_t val,
        tcb_full_pkg::tcb_sel_t ord [0:tcb_full_pkg::IFN-1]
    );
        tcb_full_pkg::tcb_vld_t res;
        for (int i = 0; i < tcb_full_pkg::IFN; i++) begin
            res[i] = val[ord[i]];
        end
        return res;
    endfunction: reorder

    // lowest set position wins
    // nothing set gives position 0
    function automatic tcb_full_pkg::tcb_sel_t encode (
        tcb_full_pkg::tcb_vld_t val
    );
        tcb_full_pkg::tcb_sel_t res;
        res = '0;
        for (int i = tcb_full_pkg::IFN-1; i >= 0; i--) begin
            if (val[i]) begin
                res = tcb_full_pkg::tcb_sel_t'(i);
            end
        end
        return res;
    endfunction: encode

//////////////////////////////////////////////////
// local signals
//////////////////////////////////////////////////

    // current priority order, highest first
    tcb_full_pkg::tcb_sel_t ord [0:tcb_full_pkg::IFN-1];
    // valids seen through the order
    tcb_full_pkg::tcb_vld_t vld_ord;
    // position of the winner within the order
    tcb_full_pkg::tcb_sel_t pos;

//////////////////////////////////////////////////
// select
//////////////////////////////////////////////////

    // purely combinational from the valids
    assign vld_ord = reorder(vld, ord);
    assign pos     = encode(vld_ord);

    // map winning position back to a manager index
    assign sel = ord[pos];

    // any request is granted, memory never stalls
    assign gnt = |vld;

//////////////////////////////////////////////////
// priority rotation
//////////////////////////////////////////////////

    // served manager moves to the tail
    // entries behind it shift up by one place
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ord <= tcb_full_pkg::PRI;
        end else if (xfr) begin
            for (int i = 0; i < tcb_full_pkg::IFN-1; i++) begin
                if (i >= pos) begin
                    ord[i] <= ord[i+1];
                end
            end
            ord[tcb_full_pkg::IFN-1] <= sel;
        end
    end

endmodule: tcb_full_lib_arbiter

/* rtl/tcb_full_lib_multiplexer.sv */
//////////////////////////////////////////////////
// TCB request multiplexer
// forwards the selected manager's request to the
// memory, drives ready and steers delayed read data
// back to the manager that issued the read
//////////////////////////////////////////////////

module tcb_full_lib_multiplexer (
    input  logic                   clk,
    input  logic                   rst_n,
    // manager side requests
    input  tcb_full_pkg::tcb_vld_t vld,
    input  tcb_full_pkg::tcb_vld_t wen,
    input  tcb_full_pkg::tcb_adr_t adr [tcb_full_pkg::IFN-1:0],
    input  tcb_full_pkg::tcb_ben_t ben [tcb_full_pkg::IFN-1:0],
    input  tcb_full_pkg::tcb_dat_t wdt [tcb_full_pkg::IFN-1:0],
    // arbiter decision
    input  tcb_full_pkg::tcb_sel_t sel,
    input  logic                   gnt,
    // manager side responses
    output tcb_full_pkg::tcb_vld_t rdy,
    output tcb_full_pkg::tcb_dat_t rdt [tcb_full_pkg::IFN-1:0],
    // memory request
    output logic                   mem_vld,
    output logic                   mem_wen,
    output tcb_full_pkg::tcb_adr_t mem_adr,
    output tcb_full_pkg::tcb_ben_t mem_ben,
    output tcb_full_pkg::tcb_dat_t mem_wdt,
    // memory read data DLY cycles after the transfer
    input  tcb_full_pkg::tcb_dat_t mem_rdt,
    // handshake completed, back to the arbiter
    output logic                   xfr
);

//////////////////////////////////////////////////
// local signals
//////////////////////////////////////////////////

    // read transfer this cycle
    logic                   ren;

    // select and read flag travelling with the read
    tcb_full_pkg::tcb_sel_t dly_sel [0:tcb_full_pkg::DLY-1];
    logic                   dly_ren [0:tcb_full_pkg::DLY-1];

//////////////////////////////////////////////////
// request path
//////////////////////////////////////////////////

    // selected manager gets the memory
    assign mem_vld = gnt;
    assign mem_wen = wen[sel];
    assign mem_adr = adr[sel];
    assign mem_ben = ben[sel];
    assign mem_wdt = wdt[sel];

    // ready only for the selected and requesting manager
    // combinational within the cycle
    for (genvar i = 0; i < tcb_full_pkg::IFN; i++) begin: gen_rdy
        assign rdy[i] = gnt & vld[i] & (sel == tcb_full_pkg::tcb_sel_t'(i));
    end: gen_rdy

    // memory never stalls so every handshake is a transfer
    assign xfr = |(vld & rdy);

    // only reads need a return path
    assign ren = xfr & ~mem_wen;

//////////////////////////////////////////////////
// read return pipeline
//////////////////////////////////////////////////

    // read flag follows the transfer by DLY cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < tcb_full_pkg::DLY; i++) begin
                dly_ren[i] <= 1'b0;
            end
        end else begin
            dly_ren[0] <= ren;
            for (int i = 1; i < tcb_full_pkg::DLY; i++) begin
                dly_ren[i] <= dly_ren[i-1];
            end
        end
    end

    // select of the issuing manager beside the flag
    always_ff @(posedge clk) begin
        dly_sel[0] <= sel;
        for (int i = 1; i < tcb_full_pkg::DLY; i++) begin
            dly_sel[i] <= dly_sel[i-1];
        end
    end

    // data to the issuing manager only
    // other managers see zero
    for (genvar i = 0; i < tcb_full_pkg::IFN; i++) begin: gen_rdt
        assign rdt[i] = (dly_ren[tcb_full_pkg::DLY-1] &&
                         (dly_sel[tcb_full_pkg::DLY-1] == tcb_full_pkg::tcb_sel_t'(i)))
                        ? mem_rdt : '0;
    end: gen_rdt

endmodule: tcb_full_lib_multiplexer

/* rtl/tcb_full_mem.sv */
//////////////////////////////////////////////////
// TCB memory subordinate
// word addressed, byte enabled writes,
// registered read data one cycle after the read
//////////////////////////////////////////////////

module tcb_full_mem (
    input  logic                   clk,
    input  logic                   rst_n,
    // request, always accepted
    input  logic                   vld,
    input  logic                   wen,
    input  tcb_full_pkg::tcb_adr_t adr,
    input  tcb_full_pkg::tcb_ben_t ben,
    input  tcb_full_pkg::tcb_dat_t wdt,
    // read data
    output tcb_full_pkg::tcb_dat_t rdt
);

//////////////////////////////////////////////////
// local signals
//////////////////////////////////////////////////

    // word address width
    localparam int unsigned WAW = $clog2(tcb_full_pkg::DEPTH);

    // storage
    tcb_full_pkg::tcb_dat_t mem [0:tcb_full_pkg::DEPTH-1];

    // word address, byte offset bits dropped
    logic [WAW-1:0] wad;

    // write and read strobes
    logic           wr;
    logic           rd;

    assign wad = adr[WAW+1:2];

    assign wr = vld & wen;
    assign rd = vld & ~wen;

//////////////////////////////////////////////////
// write
//////////////////////////////////////////////////

    // each enabled byte lane is written
    // disabled lanes keep their old contents
    always_ff @(posedge clk) begin
        if (wr) begin
            for (int b = 0; b < tcb_full_pkg::BEW; b++) begin
                if (ben[b]) begin
                    mem[wad][8*b +: 8] <= wdt[8*b +: 8];
                end
            end
        end
    end

//////////////////////////////////////////////////
// read
//////////////////////////////////////////////////

    // full word returned, byte enables ignored here
    // data holds between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdt <= '0;
        end else if (rd) begin
            rdt <= mem[wad];
        end
    end

endmodule: tcb_full_mem

/* rtl/tcb_full_pkg.sv */
//////////////////////////////////////////////////
// TCB interconnect package
// bus widths, manager count, read delay and the
// priority order the arbiter starts from after reset
//////////////////////////////////////////////////

package tcb_full_pkg;

//////////////////////////////////////////////////
// interconnect size
//////////////////////////////////////////////////

    // number of managers sharing the memory
    localparam int unsigned IFN = 3;
    // width of a manager index
    localparam int unsigned IFL = 2;

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

    // byte address, memory decodes bits 7:2
    localparam int unsigned ADW = 8;
    // data bus width
    localparam int unsigned DBW = 32;
    // one enable per data byte
    localparam int unsigned BEW = DBW / 8;

    // read data arrives this many cycles after the transfer
    localparam int unsigned DLY = 1;

    // memory size in 32-bit words
    localparam int unsigned DEPTH = 64;

//////////////////////////////////////////////////
// types
//////////////////////////////////////////////////

    // byte address
    typedef logic [ADW-1:0] tcb_adr_t;
    // read/write data word
    typedef logic [DBW-1:0] tcb_dat_t;
    // byte enables
    typedef logic [BEW-1:0] tcb_ben_t;
    // manager index
    typedef logic [IFL-1:0] tcb_sel_t;
    // one bit per manager
    typedef logic [IFN-1:0] tcb_vld_t;

    // priority order after reset, highest first
    // arbiter rotates away from this after each transfer
    localparam tcb_sel_t PRI [0:IFN-1] = '{2'd0, 2'd1, 2'd2};

endpackage: tcb_full_pkg

/* rtl/tcb_full_sys.sv */
//////////////////////////////////////////////////
// TCB three manager system
// three manager ports share one memory through
// a round-robin arbiter and a request multiplexer
//////////////////////////////////////////////////

module tcb_full_sys (
    input  logic                   clk,
    input  logic                   rst_n,
    // manager 0
    input  logic                   vld_0,
    input  logic                   wen_0,
    input  tcb_full_pkg::tcb_adr_t adr_0,
    input  tcb_full_pkg::tcb_ben_t ben_0,
    input  tcb_full_pkg::tcb_dat_t wdt_0,
    output logic                   rdy_0,
    output tcb_full_pkg::tcb_dat_t rdt_0,
    // manager 1
    input  logic                   vld_1,
    input  logic                   wen_1,
    input  tcb_full_pkg::tcb_adr_t adr_1,
    input  tcb_full_pkg::tcb_ben_t ben_1,
    input  tcb_full_pkg::tcb_dat_t wdt_1,
    output logic                   rdy_1,
    output tcb_full_pkg::tcb_dat_t rdt_1,
    // manager 2
    input  logic                   vld_2,
    input  logic                   wen_2,
    input  tcb_full_pkg::tcb_adr_t adr_2,
    input  tcb_full_pkg::tcb_ben_t ben_2,
    input  tcb_full_pkg::tcb_dat_t wdt_2,
    output logic                   rdy_2,
    output tcb_full_pkg::tcb_dat_t rdt_2
);

//////////////////////////////////////////////////
// manager signals gathered by index
//////////////////////////////////////////////////

    tcb_full_pkg::tcb_vld_t vld;
    tcb_full_pkg::tcb_vld_t wen;
    tcb_full_pkg::tcb_adr_t adr [tcb_full_pkg::IFN-1:0];
    tcb_full_pkg::tcb_ben_t ben [tcb_full_pkg::IFN-1:0];
    tcb_full_pkg::tcb_dat_t wdt [tcb_full_pkg::IFN-1:0];
    tcb_full_pkg::tcb_vld_t rdy;
    tcb_full_pkg::tcb_dat_t rdt [tcb_full_pkg::IFN-1:0];

    assign vld = {vld_2, vld_1, vld_0};
    assign wen = {wen_2, wen_1, wen_0};
    assign adr = '{adr_2, adr_1, adr_0};
    assign ben = '{ben_2, ben_1, ben_0};
    assign wdt = '{wdt_2, wdt_1, wdt_0};

    assign {rdy_2, rdy_1, rdy_0} = rdy;
    assign rdt_0 = rdt[0];
    assign rdt_1 = rdt[1];
    assign rdt_2 = rdt[2];

    // arbiter decision and feedback
    tcb_full_pkg::tcb_sel_t sel;
    logic                   gnt;
    logic                   xfr;

    // memory side request and response
    logic                   mem_vld;
    logic                   mem_wen;
    tcb_full_pkg::tcb_adr_t mem_adr;
    tcb_full_pkg::tcb_ben_t mem_ben;
    tcb_full_pkg::tcb_dat_t mem_wdt;
    tcb_full_pkg::tcb_dat_t mem_rdt;

//////////////////////////////////////////////////
// instances
//////////////////////////////////////////////////

    tcb_full_lib_arbiter arb (
        .clk   (clk),
        .rst_n (rst_n),
        .vld   (vld),
        .xfr   (xfr),
        .sel   (sel),
        .gnt   (gnt)
    );

    tcb_full_lib_multiplexer mux (
        .clk     (clk),
        .rst_n   (rst_n),
        .vld     (vld),
        .wen     (wen),
        .adr     (adr),
        .ben     (ben),
        .wdt     (wdt),
        .sel     (sel),
        .gnt     (gnt),
        .rdy     (rdy),
        .rdt     (rdt),
        .mem_vld (mem_vld),
        .mem_wen (mem_wen),
        .mem_adr (mem_adr),
        .mem_ben (mem_ben),
        .mem_wdt (mem_wdt),
        .mem_rdt (mem_rdt),
        .xfr     (xfr)
    );

    tcb_full_mem mem (
        .clk   (clk),
        .rst_n (rst_n),
        .vld   (mem_vld),
        .wen   (mem_wen),
        .adr   (mem_adr),
        .ben   (mem_ben),
        .wdt   (mem_wdt),
        .rdt   (mem_rdt)
    );

endmodule: tcb_full_sys

/* sim.f */
rtl/tcb_full_pkg.sv
rtl/tcb_full_lib_arbiter.sv
rtl/tcb_full_lib_multiplexer.sv
rtl/tcb_full_mem.sv
rtl/tcb_full_sys.sv
verif/tcb_full_clk_gen.sv
verif/tcb_full_sys_properties.sv
verif/tcb_full_sys_tb.sv

/* verif/tcb_full_clk_gen.sv */
//////////////////////////////////////////////////
// testbench clock source
// free running, 40 time units per period
//////////////////////////////////////////////////

module tcb_full_clk_gen (
    output logic clk
);

    // low at start, toggles every half period of 20
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule: tcb_full_clk_gen

/* verif/tcb_full_stim.txt */
// test | mgr 0, 1, 2 each: vld wen adr ben wdt | exp rdy | read mgr (3 none) | read data
// hex fields, one clock cycle per line, read data is checked in the following cycle
1  1 1 10 f aaaa0000  1 1 14 f bbbb0000  1 1 18 f cccc0000  1 3 00000000
2  1 1 1c f dddd0000  1 1 14 f bbbb0000  1 1 18 f cccc0000  2 3 00000000
2  1 1 1c f dddd0000  0 0 00 0 00000000  1 1 18 f cccc0000  4 3 00000000
2  1 1 1c f dddd0000  0 0 00 0 00000000  1 1 24 f ffff0000  1 3 00000000
2  1 1 20 f eeee0000  0 0 00 0 00000000  1 1 24 f ffff0000  4 3 00000000
2  1 1 20 f eeee0000  0 0 00 0 00000000  0 0 00 0 00000000  1 3 00000000
3  1 1 00 f 11111111  0 0 00 0 00000000  0 0 00 0 00000000  1 3 00000000
3  1 1 04 f 22222222  0 0 00 0 00000000  0 0 00 0 00000000  1 3 00000000
3  1 0 00 f 00000000  0 0 00 0 00000000  0 0 00 0 00000000  1 0 11111111
3  1 0 04 f 00000000  0 0 00 0 00000000  0 0 00 0 00000000  1 0 22222222
3  0 0 00 0 00000000  0 0 00 0 00000000  0 0 00 0 00000000  0 3 00000000
4  1 1 00 5 aabbccdd  0 0 00 0 00000000  0 0 00 0 00000000  1 3 00000000
4  1 1 04 a 55667788  0 0 00 0 00000000  0 0 00 0 00000000  1 3 00000000
4  1 0 00 f 00000000  0 0 00 0 00000000  0 0 00 0 00000000  1 0 11bb11dd
4  1 0 04 f 00000000  0 0 00 0 00000000  0 0 00 0 00000000  1 0 55227722
4  0 0 00 0 00000000  0 0 00 0 00000000  0 0 00 0 00000000  0 3 00000000
5  1 1 30 f 0a0a0a0a  1 1 34 f 1b1b1b1b  1 1 38 f 2c2c2c2c  2 3 00000000
5  1 1 30 f 0a0a0a0a  1 0 34 f 00000000  1 1 38 f 2c2c2c2c  4 3 00000000
5  1 1 30 f 0a0a0a0a  1 0 34 f 00000000  1 0 38 f 00000000  1 3 00000000
5  1 0 30 f 00000000  1 0 34 f 00000000  1 0 38 f 00000000  2 1 1b1b1b1b
5  1 0 30 f 00000000  0 0 00 0 00000000  1 0 38 f 00000000  4 2 2c2c2c2c
5  1 0 30 f 00000000  0 0 00 0 00000000  0 0 00 0 00000000  1 0 0a0a0a0a
6  1 0 10 f 00000000  0 0 00 0 00000000  0 0 00 0 00000000  1 0 aaaa0000
6  0 0 00 0 00000000  1 0 14 f 00000000  0 0 00 0 00000000  2 1 bbbb0000
6  0 0 00 0 00000000  0 0 00 0 00000000  1 0 18 f 00000000  4 2 cccc0000
6  0 0 00 0 00000000  1 0 1c f 00000000  0 0 00 0 00000000  2 1 dddd0000
6  0 0 00 0 00000000  0 0 00 0 00000000  1 0 24 f 00000000  4 2 ffff0000
6  1 0 20 f 00000000  0 0 00 0 00000000  0 0 00 0 00000000  1 0 eeee0000
6  0 0 00 0 00000000  0 0 00 0 00000000  0 0 00 0 00000000  0 3 00000000

/* verif/tcb_full_sys_properties.sv */
//////////////////////////////////////////////////
// TCB system bus properties
// grant and ready rules on the manager ports
//////////////////////////////////////////////////

module tcb_full_sys_properties (
    input logic clk,
    input logic rst_n,
    input logic vld_0,
    input logic vld_1,
    input logic vld_2,
    input logic rdy_0,
    input logic rdy_1,
    input logic rdy_2
);

    // number of failed assertions
    int fail_count = 0;

    // one grant at a time
    a_rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({rdy_2, rdy_1, rdy_0}))
        else begin
            fail_count++;
            $error("more than one rdy high");
        end

    // ready only towards a requesting manager
    a_rdy_vld: assert property (@(posedge clk) disable iff (!rst_n)
        ({rdy_2, rdy_1, rdy_0} & ~{vld_2, vld_1, vld_0}) == 3'b000)
        else begin
            fail_count++;
            $error("rdy high without its vld");
        end

    // quiet bus in the cycle after reset release
    a_rdy_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> ({rdy_2, rdy_1, rdy_0} == 3'b000))
        else begin
            fail_count++;
            $error("rdy high in the cycle after reset");
        end

endmodule: tcb_full_sys_properties

bind tcb_full_sys tcb_full_sys_properties props (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_0 (vld_0),
    .vld_1 (vld_1),
    .vld_2 (vld_2),
    .rdy_0 (rdy_0),
    .rdy_1 (rdy_1),
    .rdy_2 (rdy_2)
);

/* verif/tcb_full_sys_tb.sv */
//////////////////////////////////////////////////
// TCB three manager system testbench
// replays per-cycle manager requests from the
// stimulus table, checks ready and read return
//////////////////////////////////////////////////

module tcb_full_sys_tb;

    // table shape, one line per cycle
    localparam int NUM_LINES  = 29;
    localparam int NUM_FIELDS = 19;
    localparam int NUM_WORDS  = NUM_LINES * NUM_FIELDS;
    // run limit in clock cycles
    localparam int MAX_CYCLES = NUM_LINES + 20;

    logic                   clk;
    logic                   rst_n;
    logic                   vld_0, vld_1, vld_2;
    logic                   wen_0, wen_1, wen_2;
    tcb_full_pkg::tcb_adr_t adr_0, adr_1, adr_2;
    tcb_full_pkg::tcb_ben_t ben_0, ben_1, ben_2;
    tcb_full_pkg::tcb_dat_t wdt_0, wdt_1, wdt_2;
    logic                   rdy_0, rdy_1, rdy_2;
    tcb_full_pkg::tcb_dat_t rdt_0, rdt_1, rdt_2;

    // stimulus and expected values
    logic [31:0] stim [0:NUM_WORDS-1];

    // bookkeeping
    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    int test_checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    bit load_ok;

    tcb_full_clk_gen clk_gen (.clk(clk));

    tcb_full_sys dut0 (.*);

//////////////////////////////////////////////////
// table access and checks
//////////////////////////////////////////////////

    // field 0 test id, 1+5k manager k, 16 rdy, 17 read mgr, 18 read data
    function automatic logic [31:0] field_at(input int ln, input int idx);
        return stim[ln*NUM_FIELDS + idx];
    endfunction: field_at

    task automatic drive_line(input int ln);
        vld_0 <= 1'(field_at(ln, 1));
        wen_0 <= 1'(field_at(ln, 2));
        adr_0 <= tcb_full_pkg::tcb_adr_t'(field_at(ln, 3));
        ben_0 <= tcb_full_pkg::tcb_ben_t'(field_at(ln, 4));
        wdt_0 <= field_at(ln, 5);
        vld_1 <= 1'(field_at(ln, 6));
        wen_1 <= 1'(field_at(ln, 7));
        adr_1 <= tcb_full_pkg::tcb_adr_t'(field_at(ln, 8));
        ben_1 <= tcb_full_pkg::tcb_ben_t'(field_at(ln, 9));
        wdt_1 <= field_at(ln, 10);
        vld_2 <= 1'(field_at(ln, 11));
        wen_2 <= 1'(field_at(ln, 12));
        adr_2 <= tcb_full_pkg::tcb_adr_t'(field_at(ln, 13));
        ben_2 <= tcb_full_pkg::tcb_ben_t'(field_at(ln, 14));
        wdt_2 <= field_at(ln, 15);
    endtask: drive_line

    // grant of the current cycle
    task automatic check_ready(input int ln);
        logic [2:0] exp;
        logic [2:0] got;
        exp = 3'(field_at(ln, 16));
        got = {rdy_2, rdy_1, rdy_0};
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: line %0d rdy expected %b got %b",
                     $time, ln, exp, got);
            errors++;
            test_errors++;
        end
    endtask: check_ready

    // read issued on line ln, data on the issuer only, zero elsewhere
    task automatic check_read(input int ln);
        logic [31:0]            mgr;
        tcb_full_pkg::tcb_dat_t exp;
        tcb_full_pkg::tcb_dat_t got;
        mgr = field_at(ln, 17);
        for (int k = 0; k < tcb_full_pkg::IFN; k++) begin
            exp = (mgr == k) ? field_at(ln, 18) : '0;
            got = (k == 0) ? rdt_0 : ((k == 1) ? rdt_1 : rdt_2);
            checks++;
            test_checks++;
            if (got !== exp) begin
                $display("CHECK FAILED at %0t: line %0d rdt_%0d expected %h got %h",
                         $time, ln, k, exp, got);
                errors++;
                test_errors++;
            end
        end
    endtask: check_read

    task automatic finish_test(input int id);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d finished: %0d checks, %0d errors", id, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask: finish_test

//////////////////////////////////////////////////
// main sequence
//////////////////////////////////////////////////

    initial begin
        rst_n = 1'b0;
        {vld_0, vld_1, vld_2} = '0;
        {wen_0, wen_1, wen_2} = '0;
        {adr_0, adr_1, adr_2} = '0;
        {ben_0, ben_1, ben_2} = '0;
        {wdt_0, wdt_1, wdt_2} = '0;
        $readmemh("verif/tcb_full_stim.txt", stim);
        load_ok = !$isunknown(stim[NUM_WORDS-1]);
        if (!load_ok) begin
            $display("ERROR: stimulus file missing or shorter than %0d lines", NUM_LINES);
        end else begin
            repeat (2) @(posedge clk);
            rst_n <= 1'b1;
            // drive on the rising edge, sample at the falling edge
            for (int i = 0; i < NUM_LINES; i++) begin
                @(posedge clk);
                drive_line(i);
                @(negedge clk);
                if (i > 0) begin
                    check_read(i - 1);
                    if (field_at(i, 0) != field_at(i - 1, 0)) begin
                        finish_test(field_at(i - 1, 0));
                    end
                end
                check_ready(i);
            end
            // one idle cycle for the last read return
            @(posedge clk);
            {vld_0, vld_1, vld_2} <= '0;
            @(negedge clk);
            check_read(NUM_LINES - 1);
            finish_test(field_at(NUM_LINES - 1, 0));
        end
        errors = errors + dut0.props.fail_count;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (load_ok && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

endmodule: tcb_full_sys_tb
